// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with Verilator, run, then scan the log for the failure line
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_wb_top \
    -f tb.f -Mdir "$BUILD_DIR" -o Vtb_wb_top
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_wb_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished without failures"
exit 0

// ==== src/csr_file.sv ====
`timescale 1ns/1ps

module csr_file import wb_pkg::*; (
    input  logic      I_sys_clk,
    input  logic      I_rst,

    // commit from writeback
    input  logic      commit_valid,
    input  xlen_t     pc,
    input  csr_addr_t csr_addr,
    input  logic      csr_wen,
    input  xlen_t     csr_wdata,
    input  logic      csr_intr,
    input  xlen_t     csr_intr_no,
    input  logic      csr_mret,

    // read port for the upstream stages
    input  csr_addr_t csr_raddr,
    output xlen_t     csr_rdata,

    // fetch redirect
    output logic      redirect_valid,
    output xlen_t     redirect_pc
);

    xlen_t mstatus;
    xlen_t mtvec;
    xlen_t mepc;
    xlen_t mcause;
    xlen_t mscratch;

    logic  trap_commit;

    assign trap_commit = commit_valid && (csr_intr || csr_mret);

    // interrupt beats mret, mret beats a plain write
    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            mstatus        <= '0;
            mtvec          <= '0;
            mepc           <= '0;
            mcause         <= '0;
            mscratch       <= '0;
            redirect_valid <= 1'b0;
            redirect_pc    <= '0;
        end else begin
            redirect_valid <= 1'b0;
            if (commit_valid && csr_intr) begin
                mepc                  <= pc;
                mcause                <= csr_intr_no;
                mstatus[MSTATUS_MPIE] <= mstatus[MSTATUS_MIE];
                mstatus[MSTATUS_MIE]  <= 1'b0;
                redirect_valid        <= 1'b1;
                redirect_pc           <= mtvec;
            end else if (commit_valid && csr_mret) begin
                mstatus[MSTATUS_MIE]  <= mstatus[MSTATUS_MPIE];
                mstatus[MSTATUS_MPIE] <= 1'b1;
                redirect_valid        <= 1'b1;
                redirect_pc           <= mepc;
            end else if (commit_valid && csr_wen) begin
                // unknown addresses fall through untouched
                case (csr_addr)
                    CSR_MSTATUS:  mstatus  <= csr_wdata;
                    CSR_MTVEC:    mtvec    <= csr_wdata;
                    CSR_MEPC:     mepc     <= csr_wdata;
                    CSR_MCAUSE:   mcause   <= csr_wdata;
                    CSR_MSCRATCH: mscratch <= csr_wdata;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (csr_raddr)
            CSR_MSTATUS:  csr_rdata = mstatus;
            CSR_MTVEC:    csr_rdata = mtvec;
            CSR_MEPC:     csr_rdata = mepc;
            CSR_MCAUSE:   csr_rdata = mcause;
            CSR_MSCRATCH: csr_rdata = mscratch;
            default:      csr_rdata = '0;
        endcase
    end

    // back-to-back redirects need back-to-back trap commits
    a_redirect_pairs: assert property (@(posedge I_sys_clk) disable iff (I_rst)
        redirect_valid && $past(redirect_valid)
            |-> $past(trap_commit) && $past(trap_commit, 2));

endmodule

// ==== src/int_regfile.sv ====
`timescale 1ns/1ps

module int_regfile import wb_pkg::*; (
    input  logic      I_sys_clk,
    input  logic      I_rst,

    // write port
    input  logic      wen,
    input  reg_addr_t waddr,
    input  xlen_t     wdata,

    // read ports
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output xlen_t     rs1_data,
    output xlen_t     rs2_data
);

    xlen_t regs [32];

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            // x0 is hardwired, drop its writes here
            regs[waddr] <= wdata;
        end
    end

    // reads see the value from before the current edge
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // x0 storage stays zero
    a_x0_zero: assert property (@(posedge I_sys_clk) disable iff (I_rst)
        regs[0] == '0);

endmodule

// ==== src/mem_wb_reg.sv ====
`timescale 1ns/1ps

module mem_wb_reg import wb_pkg::*; (
    input  logic       I_sys_clk,
    input  logic       I_rst,

    // upstream side
    input  logic       mem_wb_valid,
    output logic       mem_wb_allowin,
    input  xlen_t      pc,
    input  xlen_t      mem_data,
    input  rstrb_t     mem_rstrb,
    input  shamt_t     mem_shamt,
    input  xlen_t      alu_out,
    input  logic       reg_wen,
    input  reg_addr_t  rd_addr,
    input  regin_sel_t regin_sel,
    input  csr_addr_t  csr_addr,
    input  logic       csr_wen,
    input  logic       csr_intr,
    input  xlen_t      csr_intr_no,
    input  logic       csr_mret,
    input  xlen_t      csr_old,
    input  inst_t      inst_debug,
    input  logic       bubble_debug,

    // writeback side
    output logic       wb_valid,
    output xlen_t      wb_pc,
    output xlen_t      wb_mem_data,
    output rstrb_t     wb_mem_rstrb,
    output shamt_t     wb_mem_shamt,
    output xlen_t      wb_alu_out,
    output logic       wb_reg_wen,
    output reg_addr_t  wb_rd_addr,
    output regin_sel_t wb_regin_sel,
    output csr_addr_t  wb_csr_addr,
    output logic       wb_csr_wen,
    output logic       wb_csr_intr,
    output xlen_t      wb_csr_intr_no,
    output logic       wb_csr_mret,
    output xlen_t      wb_csr_old,
    output inst_t      wb_inst_debug,
    output logic       wb_bubble_debug
);

    logic accept;

    // writeback retires every cycle, so allowin only drops in reset
    assign mem_wb_allowin = !I_rst;
    assign accept         = mem_wb_valid && mem_wb_allowin;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_wb_valid;
        end
    end

    // fields only load on acceptance
    always_ff @(posedge I_sys_clk) begin
        if (accept) begin
            wb_pc           <= pc;
            wb_mem_data     <= mem_data;
            wb_mem_rstrb    <= mem_rstrb;
            wb_mem_shamt    <= mem_shamt;
            wb_alu_out      <= alu_out;
            wb_reg_wen      <= reg_wen;
            wb_rd_addr      <= rd_addr;
            wb_regin_sel    <= regin_sel;
            wb_csr_addr     <= csr_addr;
            wb_csr_wen      <= csr_wen;
            wb_csr_intr     <= csr_intr;
            wb_csr_intr_no  <= csr_intr_no;
            wb_csr_mret     <= csr_mret;
            wb_csr_old      <= csr_old;
            wb_inst_debug   <= inst_debug;
            wb_bubble_debug <= bubble_debug;
        end
    end

    // upstream must hand over a single writeback source
    a_sel_onehot: assert property (@(posedge I_sys_clk) disable iff (I_rst)
        wb_valid |-> $onehot(wb_regin_sel));

endmodule

// ==== src/wb_data_select.sv ====
`timescale 1ns/1ps

module wb_data_select import wb_pkg::*; (
    input  xlen_t      mem_data,
    input  rstrb_t     mem_rstrb,
    input  shamt_t     mem_shamt,
    input  xlen_t      alu_out,
    input  xlen_t      csr_old,
    input  regin_sel_t regin_sel,
    output xlen_t      wb_data
);

    xlen_t shifted;
    xlen_t load_data;
    logic  sign_bit;
    logic  sext;

    // move the addressed bytes down to bit 0
    assign shifted = mem_data >> {mem_shamt, 3'b000};

    // msb of the highest byte the mask keeps
    always_comb begin
        sign_bit = 1'b0;
        for (int i = 0; i < XLEN_BYTES; i++) begin
            if (mem_rstrb[i]) begin
                sign_bit = shifted[8*i+7];
            end
        end
    end

    assign sext = mem_rstrb[RSTRB_SIGN] && sign_bit;

    // kept bytes pass, the rest fill with the extension byte
    always_comb begin
        for (int i = 0; i < XLEN_BYTES; i++) begin
            if (mem_rstrb[i]) begin
                load_data[8*i +: 8] = shifted[8*i +: 8];
            end else begin
                load_data[8*i +: 8] = {8{sext}};
            end
        end
    end

    // one-hot and-or select of the writeback source
    assign wb_data = ({64{regin_sel[WB_SRC_ALU]}} & alu_out)
                   | ({64{regin_sel[WB_SRC_MEM]}} & load_data)
                   | ({64{regin_sel[WB_SRC_CSR]}} & csr_old);

endmodule

// ==== src/wb_pkg.sv ====
package wb_pkg;

    // data, pc and csr values
    typedef logic [63:0] xlen_t;

    // integer register index
    typedef logic [4:0] reg_addr_t;

    // machine csr address space
    typedef logic [11:0] csr_addr_t;

    // raw instruction word, debug only
    typedef logic [31:0] inst_t;

    // load strobe
    // bits 7:0 are a low-aligned byte mask (01, 03, 0f, ff), bit 8 asks for sign extension
    // all zeros means the item is not a load
    typedef logic [8:0] rstrb_t;

    // byte offset of the load inside the 64-bit word
    typedef logic [2:0] shamt_t;

    // one-hot writeback source
    typedef logic [2:0] regin_sel_t;

    localparam int WB_SRC_ALU = 0;
    localparam int WB_SRC_MEM = 1;
    localparam int WB_SRC_CSR = 2;

    // load strobe layout
    localparam int RSTRB_SIGN = 8;
    localparam int XLEN_BYTES = 8;

    // machine-mode csr addresses
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;

    // mstatus bit positions
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;

endpackage

// ==== src/wb_top.sv ====
`timescale 1ns/1ps

module wb_top import wb_pkg::*; (
    input  logic       I_sys_clk,
    input  logic       I_rst,

    // item from the memory stage
    input  logic       mem_wb_valid,
    output logic       mem_wb_allowin,
    input  xlen_t      pc,
    input  xlen_t      mem_data,
    input  rstrb_t     mem_rstrb,
    input  shamt_t     mem_shamt,
    input  xlen_t      alu_out,
    input  logic       reg_wen,
    input  reg_addr_t  rd_addr,
    input  regin_sel_t regin_sel,
    input  csr_addr_t  csr_addr,
    input  logic       csr_wen,
    input  logic       csr_intr,
    input  xlen_t      csr_intr_no,
    input  logic       csr_mret,
    input  xlen_t      csr_old,
    input  inst_t      inst_debug,
    input  logic       bubble_debug,

    // read ports for decode
    input  reg_addr_t  rs1_addr,
    input  reg_addr_t  rs2_addr,
    output xlen_t      rs1_data,
    output xlen_t      rs2_data,
    input  csr_addr_t  csr_raddr,
    output xlen_t      csr_rdata,

    // to fetch
    output logic       redirect_valid,
    output xlen_t      redirect_pc,

    // retire trace
    output logic       retire_valid,
    output xlen_t      retire_pc,
    output inst_t      retire_inst,
    output logic       retire_bubble,
    output xlen_t      retire_wdata
);

    logic       wb_valid;
    xlen_t      wb_pc;
    xlen_t      wb_mem_data;
    rstrb_t     wb_mem_rstrb;
    shamt_t     wb_mem_shamt;
    xlen_t      wb_alu_out;
    logic       wb_reg_wen;
    reg_addr_t  wb_rd_addr;
    regin_sel_t wb_regin_sel;
    csr_addr_t  wb_csr_addr;
    logic       wb_csr_wen;
    logic       wb_csr_intr;
    xlen_t      wb_csr_intr_no;
    logic       wb_csr_mret;
    xlen_t      wb_csr_old;
    inst_t      wb_inst_debug;
    logic       wb_bubble_debug;
    xlen_t      wb_data;

    mem_wb_reg u_mem_wb_reg (
        .I_sys_clk       (I_sys_clk),
        .I_rst           (I_rst),
        .mem_wb_valid    (mem_wb_valid),
        .mem_wb_allowin  (mem_wb_allowin),
        .pc              (pc),
        .mem_data        (mem_data),
        .mem_rstrb       (mem_rstrb),
        .mem_shamt       (mem_shamt),
        .alu_out         (alu_out),
        .reg_wen         (reg_wen),
        .rd_addr         (rd_addr),
        .regin_sel       (regin_sel),
        .csr_addr        (csr_addr),
        .csr_wen         (csr_wen),
        .csr_intr        (csr_intr),
        .csr_intr_no     (csr_intr_no),
        .csr_mret        (csr_mret),
        .csr_old         (csr_old),
        .inst_debug      (inst_debug),
        .bubble_debug    (bubble_debug),
        .wb_valid        (wb_valid),
        .wb_pc           (wb_pc),
        .wb_mem_data     (wb_mem_data),
        .wb_mem_rstrb    (wb_mem_rstrb),
        .wb_mem_shamt    (wb_mem_shamt),
        .wb_alu_out      (wb_alu_out),
        .wb_reg_wen      (wb_reg_wen),
        .wb_rd_addr      (wb_rd_addr),
        .wb_regin_sel    (wb_regin_sel),
        .wb_csr_addr     (wb_csr_addr),
        .wb_csr_wen      (wb_csr_wen),
        .wb_csr_intr     (wb_csr_intr),
        .wb_csr_intr_no  (wb_csr_intr_no),
        .wb_csr_mret     (wb_csr_mret),
        .wb_csr_old      (wb_csr_old),
        .wb_inst_debug   (wb_inst_debug),
        .wb_bubble_debug (wb_bubble_debug)
    );

    wb_data_select u_wb_data_select (
        .mem_data  (wb_mem_data),
        .mem_rstrb (wb_mem_rstrb),
        .mem_shamt (wb_mem_shamt),
        .alu_out   (wb_alu_out),
        .csr_old   (wb_csr_old),
        .regin_sel (wb_regin_sel),
        .wb_data   (wb_data)
    );

    // x0 filtering is left to the register file
    int_regfile u_int_regfile (
        .I_sys_clk (I_sys_clk),
        .I_rst     (I_rst),
        .wen       (wb_valid && wb_reg_wen),
        .waddr     (wb_rd_addr),
        .wdata     (wb_data),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data)
    );

    // csr writes take the new value computed upstream in alu_out
    csr_file u_csr_file (
        .I_sys_clk      (I_sys_clk),
        .I_rst          (I_rst),
        .commit_valid   (wb_valid),
        .pc             (wb_pc),
        .csr_addr       (wb_csr_addr),
        .csr_wen        (wb_csr_wen),
        .csr_wdata      (wb_alu_out),
        .csr_intr       (wb_csr_intr),
        .csr_intr_no    (wb_csr_intr_no),
        .csr_mret       (wb_csr_mret),
        .csr_raddr      (csr_raddr),
        .csr_rdata      (csr_rdata),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    assign retire_valid  = wb_valid;
    assign retire_pc     = wb_pc;
    assign retire_inst   = wb_inst_debug;
    assign retire_bubble = wb_bubble_debug;
    assign retire_wdata  = wb_data;

endmodule

// ==== tb.f ====
src/wb_pkg.sv
src/mem_wb_reg.sv
src/wb_data_select.sv
src/int_regfile.sv
src/csr_file.sv
src/wb_top.sv
test/tb_wb_top.sv

// ==== test/tb_wb_top.sv ====
`timescale 1ns/1ps

module tb_wb_top import wb_pkg::*; ();

    localparam int  N_ITEMS      = 400;
    localparam int  RESET_CYCLES = 5;
    localparam real CLK_PERIOD   = 100.0;

    logic       I_sys_clk;
    logic       I_rst;
    logic       mem_wb_valid;
    logic       mem_wb_allowin;
    xlen_t      pc;
    xlen_t      mem_data;
    rstrb_t     mem_rstrb;
    shamt_t     mem_shamt;
    xlen_t      alu_out;
    logic       reg_wen;
    reg_addr_t  rd_addr;
    regin_sel_t regin_sel;
    csr_addr_t  csr_addr;
    logic       csr_wen;
    logic       csr_intr;
    xlen_t      csr_intr_no;
    logic       csr_mret;
    xlen_t      csr_old;
    inst_t      inst_debug;
    logic       bubble_debug;
    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    xlen_t      rs1_data;
    xlen_t      rs2_data;
    csr_addr_t  csr_raddr;
    xlen_t      csr_rdata;
    logic       redirect_valid;
    xlen_t      redirect_pc;
    logic       retire_valid;
    xlen_t      retire_pc;
    inst_t      retire_inst;
    logic       retire_bubble;
    xlen_t      retire_wdata;

    integer seed;
    int     n_checks;
    int     n_errors;

    // reference state
    xlen_t regs_m [32];
    xlen_t mstatus_m;
    xlen_t mtvec_m;
    xlen_t mepc_m;
    xlen_t mcause_m;
    xlen_t mscratch_m;

    // item the model holds in the writeback stage
    logic      s_valid;
    logic      s_bubble;
    logic      s_reg_wen;
    logic      s_csr_wen;
    logic      s_intr;
    logic      s_mret;
    xlen_t     s_pc;
    xlen_t     s_wdata;
    xlen_t     s_alu;
    xlen_t     s_intr_no;
    inst_t     s_inst;
    reg_addr_t s_rd;
    csr_addr_t s_csr_addr;
    logic      exp_redirect;
    xlen_t     exp_redirect_pc;

    wb_top dut0 (.*);

    initial I_sys_clk = 1'b0;
    always #(CLK_PERIOD / 2.0) I_sys_clk = ~I_sys_clk;

    task automatic check_xlen(input string what, input xlen_t got, input xlen_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_inst(input string what, input inst_t got, input inst_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic xlen_t rand64();
        xlen_t v;
        v[63:32] = $random(seed);
        v[31:0]  = $random(seed);
        return v;
    endfunction

    // mostly known csrs, sometimes an unused address in 0x7c0..0x7cf
    function automatic csr_addr_t pick_csr_addr();
        case (rand_below(6))
            0:       return CSR_MSTATUS;
            1:       return CSR_MTVEC;
            2:       return CSR_MEPC;
            3:       return CSR_MCAUSE;
            4:       return CSR_MSCRATCH;
            default: return 12'h7c0 | csr_addr_t'(rand_below(16));
        endcase
    endfunction

    function automatic logic [7:0] pick_mask();
        case (rand_below(4))
            0:       return 8'h01;
            1:       return 8'h03;
            2:       return 8'h0f;
            default: return 8'hff;
        endcase
    endfunction

    // load width from the mask, then shift, truncate and extend
    function automatic xlen_t expect_load(xlen_t data, rstrb_t strb, shamt_t sh);
        xlen_t raw;
        xlen_t keep;
        int    nbytes;
        case (strb[7:0])
            8'h01:   nbytes = 1;
            8'h03:   nbytes = 2;
            8'h0f:   nbytes = 4;
            8'hff:   nbytes = 8;
            default: nbytes = 0;
        endcase
        if (nbytes == 0) begin
            return '0;
        end
        raw = data >> (8 * sh);
        if (nbytes < 8) begin
            keep = (64'd1 << (8 * nbytes)) - 64'd1;
            raw  = raw & keep;
            if (strb[RSTRB_SIGN] && raw[8*nbytes-1]) begin
                raw = raw | ~keep;
            end
        end
        return raw;
    endfunction

    function automatic xlen_t expect_wdata(regin_sel_t sel, xlen_t load, xlen_t alu,
                                           xlen_t old);
        if (sel[WB_SRC_MEM]) begin
            return load;
        end else if (sel[WB_SRC_CSR]) begin
            return old;
        end
        return alu;
    endfunction

    function automatic xlen_t read_csr_model(csr_addr_t a);
        case (a)
            CSR_MSTATUS:  return mstatus_m;
            CSR_MTVEC:    return mtvec_m;
            CSR_MEPC:     return mepc_m;
            CSR_MCAUSE:   return mcause_m;
            CSR_MSCRATCH: return mscratch_m;
            default:      return '0;
        endcase
    endfunction

    task automatic drive_item();
        regin_sel_t sel;
        sel = regin_sel_t'(1 << rand_below(3));
        mem_wb_valid <= rand_below(5) != 0;
        pc           <= rand64() & ~64'h3;
        mem_data     <= rand64();
        // loads always carry a strobe, other items only sometimes
        if (sel[WB_SRC_MEM] || rand_below(2) == 0) begin
            mem_rstrb <= {rand_below(2) == 0, pick_mask()};
        end else begin
            mem_rstrb <= '0;
        end
        mem_shamt    <= shamt_t'(rand_below(8));
        alu_out      <= rand64();
        reg_wen      <= rand_below(4) != 0;
        rd_addr      <= reg_addr_t'(rand_below(32));
        regin_sel    <= sel;
        csr_addr     <= pick_csr_addr();
        csr_wen      <= rand_below(2) == 0;
        csr_intr     <= rand_below(8) == 0;
        csr_intr_no  <= rand64();
        csr_mret     <= rand_below(8) == 0;
        csr_old      <= rand64();
        inst_debug   <= inst_t'($random(seed));
        bubble_debug <= rand_below(8) == 0;
        rs1_addr     <= reg_addr_t'(rand_below(32));
        rs2_addr     <= reg_addr_t'(rand_below(32));
        csr_raddr    <= pick_csr_addr();
    endtask

    // effect of the edge on the item that sat in writeback
    task automatic commit_stage();
        logic old_mie;
        exp_redirect = 1'b0;
        if (s_valid) begin
            if (s_reg_wen && s_rd != '0) begin
                regs_m[s_rd] = s_wdata;
            end
            if (s_intr) begin
                exp_redirect            = 1'b1;
                exp_redirect_pc         = mtvec_m;
                old_mie                 = mstatus_m[MSTATUS_MIE];
                mepc_m                  = s_pc;
                mcause_m                = s_intr_no;
                mstatus_m[MSTATUS_MPIE] = old_mie;
                mstatus_m[MSTATUS_MIE]  = 1'b0;
            end else if (s_mret) begin
                exp_redirect            = 1'b1;
                exp_redirect_pc         = mepc_m;
                mstatus_m[MSTATUS_MIE]  = mstatus_m[MSTATUS_MPIE];
                mstatus_m[MSTATUS_MPIE] = 1'b1;
            end else if (s_csr_wen) begin
                case (s_csr_addr)
                    CSR_MSTATUS:  mstatus_m  = s_alu;
                    CSR_MTVEC:    mtvec_m    = s_alu;
                    CSR_MEPC:     mepc_m     = s_alu;
                    CSR_MCAUSE:   mcause_m   = s_alu;
                    CSR_MSCRATCH: mscratch_m = s_alu;
                    default: ;
                endcase
            end
        end
    endtask

    // allowin is always high here, so an offered item is taken
    task automatic capture_stage();
        s_valid = mem_wb_valid;
        if (mem_wb_valid) begin
            s_pc       = pc;
            s_inst     = inst_debug;
            s_bubble   = bubble_debug;
            s_reg_wen  = reg_wen;
            s_rd       = rd_addr;
            s_csr_addr = csr_addr;
            s_csr_wen  = csr_wen;
            s_intr     = csr_intr;
            s_intr_no  = csr_intr_no;
            s_mret     = csr_mret;
            s_alu      = alu_out;
            s_wdata    = expect_wdata(regin_sel, expect_load(mem_data, mem_rstrb, mem_shamt),
                                      alu_out, csr_old);
        end
    endtask

    task automatic check_outputs();
        check_bit("mem_wb_allowin", mem_wb_allowin, 1'b1);
        check_bit("retire_valid", retire_valid, s_valid);
        if (s_valid) begin
            check_xlen("retire_pc", retire_pc, s_pc);
            check_inst("retire_inst", retire_inst, s_inst);
            check_bit("retire_bubble", retire_bubble, s_bubble);
            check_xlen("retire_wdata", retire_wdata, s_wdata);
        end
        check_xlen("rs1_data", rs1_data, regs_m[rs1_addr]);
        check_xlen("rs2_data", rs2_data, regs_m[rs2_addr]);
        check_xlen("csr_rdata", csr_rdata, read_csr_model(csr_raddr));
        check_bit("redirect_valid", redirect_valid, exp_redirect);
        if (exp_redirect) begin
            check_xlen("redirect_pc", redirect_pc, exp_redirect_pc);
        end
    endtask

    initial begin
        #((N_ITEMS * 3 + RESET_CYCLES) * CLK_PERIOD);
        $display("timeout: the run did not reach its end within the watchdog limit");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        seed         = 14557;
        n_checks     = 0;
        n_errors     = 0;
        I_rst        = 1'b1;
        mem_wb_valid = 1'b0;
        pc           = '0;
        mem_data     = '0;
        mem_rstrb    = '0;
        mem_shamt    = '0;
        alu_out      = '0;
        reg_wen      = 1'b0;
        rd_addr      = '0;
        regin_sel    = regin_sel_t'(1);
        csr_addr     = '0;
        csr_wen      = 1'b0;
        csr_intr     = 1'b0;
        csr_intr_no  = '0;
        csr_mret     = 1'b0;
        csr_old      = '0;
        inst_debug   = '0;
        bubble_debug = 1'b0;
        rs1_addr     = '0;
        rs2_addr     = '0;
        csr_raddr    = '0;
        for (int i = 0; i < 32; i++) begin
            regs_m[i] = '0;
        end
        mstatus_m       = '0;
        mtvec_m         = '0;
        mepc_m          = '0;
        mcause_m        = '0;
        mscratch_m      = '0;
        s_valid         = 1'b0;
        exp_redirect    = 1'b0;
        exp_redirect_pc = '0;

        repeat (RESET_CYCLES) @(posedge I_sys_clk);
        I_rst <= 1'b0;

        // two extra cycles drain the last item
        for (int n = 0; n < N_ITEMS + 2; n++) begin
            @(posedge I_sys_clk);
            commit_stage();
            capture_stage();
            if (n < N_ITEMS) begin
                drive_item();
            end else begin
                mem_wb_valid <= 1'b0;
            end
            @(negedge I_sys_clk);
            check_outputs();
        end

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
